//--- hdl/axi_ic_pkg.sv
package axi_ic_pkg;

    // Write address channel
    localparam int addr_w = 32;

    // Burst length field, beats minus one
    localparam int len_w = 8;

    // Write data channel
    localparam int data_w = 32;

    // One strobe bit per data byte
    localparam int strb_w = data_w / 8;

    // Write response code
    localparam int resp_w = 2;

endpackage

//--- hdl/aw_rr_arbiter.sv
module aw_rr_arbiter #(
    parameter int master_n = 4,
    parameter int id_w = 2
)(
    input  logic                                   clk,
    input  logic                                   rst_n,

    // Master side AW requests
    input  logic [master_n*axi_ic_pkg::addr_w-1:0] s_awaddr,
    input  logic [master_n*axi_ic_pkg::len_w-1:0]  s_awlen,
    input  logic [master_n-1:0]                    s_awvalid,
    output logic [master_n-1:0]                    s_awready,

    // Slave side AW
    output logic [axi_ic_pkg::addr_w-1:0]          m_awaddr,
    output logic [axi_ic_pkg::len_w-1:0]           m_awlen,
    output logic [id_w-1:0]                        m_awid,
    output logic                                   m_awvalid,
    input  logic                                   m_awready,

    // Grant queue write side
    output logic                                   grant_push,
    output logic [id_w-1:0]                        grant_index,
    input  logic                                   grant_not_full
);

    import axi_ic_pkg::*;

    logic [id_w-1:0] last_winner;
    logic [id_w-1:0] win_index;
    logic            win_found;
    logic            slot_free;
    logic            take;

    // Slot is free when empty or handed over this cycle
    assign slot_free = !m_awvalid || m_awready;

    assign take = slot_free && grant_not_full && win_found;

    // Rotating priority, starting one past the last winner
    always_comb
    begin : rr_search
        int cand;
        cand = 0;
        win_found = 1'b0;
        win_index = last_winner;
        for (int i = 1; i <= master_n; i++)
        begin
            cand = (int'(last_winner) + i) % master_n;
            if (!win_found && s_awvalid[cand])
            begin
                win_found = 1'b1;
                win_index = id_w'(cand);
            end
        end
    end

    // Only the winner sees ready
    always_comb
    begin
        s_awready = '0;
        for (int k = 0; k < master_n; k++)
        begin
            s_awready[k] = take && (win_index == id_w'(k));
        end
    end

    // Same decision enters the grant queue
    assign grant_push  = take;
    assign grant_index = win_index;

    // Slot valid and round-robin pointer
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_awvalid   <= 1'b0;
            // Master 0 goes first after reset
            last_winner <= id_w'(master_n - 1);
        end
        else
        begin
            if (take)
            begin
                m_awvalid   <= 1'b1;
                last_winner <= win_index;
            end
            else if (m_awready)
            begin
                m_awvalid <= 1'b0;
            end
        end
    end

    // Slot payload, held while the slave stalls
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            m_awaddr <= s_awaddr[win_index*addr_w +: addr_w];
            m_awlen  <= s_awlen[win_index*len_w +: len_w];
            m_awid   <= win_index;
        end
    end

endmodule

//--- hdl/grant_queue.sv
module grant_queue #(
    parameter int width = 2,
    parameter int depth = 4
)(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [width-1:0] push_data,
    input  logic             pop,
    output logic             not_full,
    output logic [width-1:0] head_data,
    output logic             head_valid
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] fill;

    // Wraps for depths that are not a power of two
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1))
            return '0;
        else
            return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            if (push && !pop)
                fill <= fill + 1'b1;
            else if (pop && !push)
                fill <= fill - 1'b1;
        end
    end

    // Head word shows without a read cycle
    assign head_data  = mem[rd_ptr];
    assign head_valid = (fill != '0);
    assign not_full   = (fill != cnt_w'(depth));

endmodule

//--- hdl/wb_router.sv
module wb_router #(
    parameter int master_n = 4,
    parameter int id_w = 2
)(
    // Grant queue head
    input  logic [id_w-1:0]                        head_index,
    input  logic                                   head_valid,
    output logic                                   grant_pop,

    // Master side W
    input  logic [master_n*axi_ic_pkg::data_w-1:0] s_wdata,
    input  logic [master_n*axi_ic_pkg::strb_w-1:0] s_wstrb,
    input  logic [master_n-1:0]                    s_wlast,
    input  logic [master_n-1:0]                    s_wvalid,
    output logic [master_n-1:0]                    s_wready,

    // Slave side W
    output logic [axi_ic_pkg::data_w-1:0]          m_wdata,
    output logic [axi_ic_pkg::strb_w-1:0]          m_wstrb,
    output logic                                   m_wlast,
    output logic                                   m_wvalid,
    input  logic                                   m_wready,

    // Slave side B
    input  logic [axi_ic_pkg::resp_w-1:0]          m_bresp,
    input  logic [id_w-1:0]                        m_bid,
    input  logic                                   m_bvalid,
    output logic                                   m_bready,

    // Master side B
    output logic [master_n*axi_ic_pkg::resp_w-1:0] s_bresp,
    output logic [master_n-1:0]                    s_bvalid,
    input  logic [master_n-1:0]                    s_bready
);

    import axi_ic_pkg::*;

    // W payload of the master at the queue head
    assign m_wdata  = s_wdata[head_index*data_w +: data_w];
    assign m_wstrb  = s_wstrb[head_index*strb_w +: strb_w];
    assign m_wlast  = s_wlast[head_index];
    assign m_wvalid = head_valid && s_wvalid[head_index];

    // Ready goes back to the head master only
    always_comb
    begin
        s_wready = '0;
        for (int k = 0; k < master_n; k++)
        begin
            s_wready[k] = head_valid && (head_index == id_w'(k)) && m_wready;
        end
    end

    // Burst done, next grant comes up
    assign grant_pop = m_wvalid && m_wready && m_wlast;

    // Response code is common to all masters
    assign s_bresp = {master_n{m_bresp}};

    // Valid and ready steered by the returned ID
    always_comb
    begin
        s_bvalid = '0;
        m_bready = 1'b0;
        for (int k = 0; k < master_n; k++)
        begin
            if (m_bid == id_w'(k))
            begin
                s_bvalid[k] = m_bvalid;
                m_bready    = s_bready[k];
            end
        end
    end

endmodule

//--- hdl/axi_nm1s_wr_interconnect.sv
module axi_nm1s_wr_interconnect #(
    parameter int master_n = 4,
    parameter int grant_depth = 4,
    localparam int id_w = $clog2(master_n)
)(
    input  logic                                   clk,
    input  logic                                   rst_n,

    // Master side AW
    input  logic [master_n*axi_ic_pkg::addr_w-1:0] s_awaddr,
    input  logic [master_n*axi_ic_pkg::len_w-1:0]  s_awlen,
    input  logic [master_n-1:0]                    s_awvalid,
    output logic [master_n-1:0]                    s_awready,

    // Master side W
    input  logic [master_n*axi_ic_pkg::data_w-1:0] s_wdata,
    input  logic [master_n*axi_ic_pkg::strb_w-1:0] s_wstrb,
    input  logic [master_n-1:0]                    s_wlast,
    input  logic [master_n-1:0]                    s_wvalid,
    output logic [master_n-1:0]                    s_wready,

    // Master side B
    output logic [master_n*axi_ic_pkg::resp_w-1:0] s_bresp,
    output logic [master_n-1:0]                    s_bvalid,
    input  logic [master_n-1:0]                    s_bready,

    // Slave side AW
    output logic [axi_ic_pkg::addr_w-1:0]          m_awaddr,
    output logic [axi_ic_pkg::len_w-1:0]           m_awlen,
    output logic [id_w-1:0]                        m_awid,
    output logic                                   m_awvalid,
    input  logic                                   m_awready,

    // Slave side W
    output logic [axi_ic_pkg::data_w-1:0]          m_wdata,
    output logic [axi_ic_pkg::strb_w-1:0]          m_wstrb,
    output logic                                   m_wlast,
    output logic                                   m_wvalid,
    input  logic                                   m_wready,

    // Slave side B
    input  logic [axi_ic_pkg::resp_w-1:0]          m_bresp,
    input  logic [id_w-1:0]                        m_bid,
    input  logic                                   m_bvalid,
    output logic                                   m_bready
);

    logic            grant_push;
    logic [id_w-1:0] grant_index;
    logic            grant_not_full;
    logic [id_w-1:0] head_index;
    logic            head_valid;
    logic            grant_pop;

    aw_rr_arbiter #(
        .master_n (master_n),
        .id_w     (id_w)
    ) i_aw_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_awaddr       (s_awaddr),
        .s_awlen        (s_awlen),
        .s_awvalid      (s_awvalid),
        .s_awready      (s_awready),
        .m_awaddr       (m_awaddr),
        .m_awlen        (m_awlen),
        .m_awid         (m_awid),
        .m_awvalid      (m_awvalid),
        .m_awready      (m_awready),
        .grant_push     (grant_push),
        .grant_index    (grant_index),
        .grant_not_full (grant_not_full)
    );

    // Grants in address order, one entry per accepted AW
    grant_queue #(
        .width (id_w),
        .depth (grant_depth)
    ) i_grant_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (grant_push),
        .push_data  (grant_index),
        .pop        (grant_pop),
        .not_full   (grant_not_full),
        .head_data  (head_index),
        .head_valid (head_valid)
    );

    wb_router #(
        .master_n (master_n),
        .id_w     (id_w)
    ) i_wb_router (
        .head_index (head_index),
        .head_valid (head_valid),
        .grant_pop  (grant_pop),
        .s_wdata    (s_wdata),
        .s_wstrb    (s_wstrb),
        .s_wlast    (s_wlast),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .m_wdata    (m_wdata),
        .m_wstrb    (m_wstrb),
        .m_wlast    (m_wlast),
        .m_wvalid   (m_wvalid),
        .m_wready   (m_wready),
        .m_bresp    (m_bresp),
        .m_bid      (m_bid),
        .m_bvalid   (m_bvalid),
        .m_bready   (m_bready),
        .s_bresp    (s_bresp),
        .s_bvalid   (s_bvalid),
        .s_bready   (s_bready)
    );

endmodule

//--- bench/tb_axi_nm1s_wr_interconnect_sva.sv
module tb_axi_nm1s_wr_interconnect_sva #(
    parameter int master_n = 4,
    parameter int id_w = 2
)(
    input logic                  clk,
    input logic                  rst_n,
    input logic [31:0]           m_awaddr,
    input logic [7:0]            m_awlen,
    input logic [id_w-1:0]       m_awid,
    input logic                  m_awvalid,
    input logic                  m_awready,
    input logic [master_n-1:0]   s_awready,
    input logic                  grant_pop,
    input logic                  head_valid
);

    // Slot stays put while the slave stalls
    aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr) && $stable(m_awlen)
            && $stable(m_awid))
        else $error("m_aw slot changed before m_awready");

    aw_one_ready: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(s_awready))
        else $error("more than one s_awready high");

    no_empty_pop: assert property (@(posedge clk) disable iff (!rst_n) grant_pop |-> head_valid)
        else $error("grant queue popped while empty");

endmodule

bind axi_nm1s_wr_interconnect tb_axi_nm1s_wr_interconnect_sva #(
    .master_n (master_n),
    .id_w     (id_w)
) i_sva (.*);

//--- bench/tb_axi_nm1s_wr_interconnect.sv
module tb_axi_nm1s_wr_interconnect;

    import axi_ic_pkg::*;

    localparam int master_n = 4;
    localparam int id_w = 2;
    localparam int grant_depth = 4;

    logic clk = 1'b0;
    logic rst_n;
    logic [master_n*addr_w-1:0] s_awaddr;
    logic [master_n*len_w-1:0]  s_awlen;
    logic [master_n-1:0]        s_awvalid, s_awready;
    logic [master_n*data_w-1:0] s_wdata;
    logic [master_n*strb_w-1:0] s_wstrb;
    logic [master_n-1:0]        s_wlast, s_wvalid, s_wready;
    logic [master_n*resp_w-1:0] s_bresp;
    logic [master_n-1:0]        s_bvalid, s_bready;
    logic [addr_w-1:0]          m_awaddr;
    logic [len_w-1:0]           m_awlen;
    logic [id_w-1:0]            m_awid, m_bid;
    logic                       m_awvalid, m_awready;
    logic [data_w-1:0]          m_wdata;
    logic [strb_w-1:0]          m_wstrb;
    logic                       m_wlast, m_wvalid, m_wready;
    logic [resp_w-1:0]          m_bresp;
    logic                       m_bvalid, m_bready;

    // Master models: pending AW, beats {last, strb, data}, expected B codes
    logic [addr_w-1:0] aw_addr_q [master_n][$];
    logic [len_w-1:0]  aw_len_q [master_n][$];
    logic [36:0]       beat_q [master_n][$];
    logic [36:0]       exp_beat_q [master_n][$];
    logic [1:0]        exp_b_q [master_n][$];
    logic [41:0]       exp_aw_q [$];
    logic [9:0]        w_ord_q [$];
    logic [3:0]        slv_aw_q [$];
    logic [master_n-1:0] w_taken;
    logic b_taken, stall_on, w_hold;
    integer seed = 32'h78fa;
    int ref_last = master_n - 1;
    int err_count = 0, tx_count = 0, b_count = 0, aw_accepted = 0;
    int wlast_done = 0, beat_cnt = 0, budget = 200, cycles = 0;
    string test_name = "reset";

    axi_nm1s_wr_interconnect #(.master_n(master_n), .grant_depth(grant_depth)) i_dut (.*);

    initial
    begin
        forever #2 clk = ~clk;
    end

    // Expected round-robin winner for a request vector
    function automatic int rr_winner(input logic [master_n-1:0] req, input int last);
        int c;
        for (int i = 1; i <= master_n; i++)
        begin
            c = (last + i) % master_n;
            if (req[c])
                return c;
        end
        return -1;
    endfunction

    task automatic compare_field(input string field, input longint expected, input longint actual);
        assert (expected == actual)
        else
        begin
            $display("Error: test %s %s expected %0h actual %0h", test_name, field,
                     expected, actual);
            err_count++;
        end
    endtask

    task automatic new_write(input int k, input logic [addr_w-1:0] addr, input int len);
        logic [36:0] beat;
        aw_addr_q[k].push_back(addr);
        aw_len_q[k].push_back(len_w'(len));
        for (int b = 0; b <= len; b++)
        begin
            beat = {b == len, 4'($random(seed)), 32'($random(seed))};
            beat_q[k].push_back(beat);
            exp_beat_q[k].push_back(beat);
        end
        tx_count++;
        budget += (len + 5) * 16;
    endtask

    task automatic drive_inputs();
        for (int k = 0; k < master_n; k++)
        begin
            s_awvalid[k] = aw_addr_q[k].size() != 0;
            if (s_awvalid[k])
            begin
                s_awaddr[k*addr_w +: addr_w] = aw_addr_q[k][0];
                s_awlen[k*len_w +: len_w] = aw_len_q[k][0];
            end
            if (w_taken[k])
                s_wvalid[k] = 1'b0;
            if (!s_wvalid[k] && !w_hold && beat_q[k].size() != 0 && {$random(seed)} % 4 != 0)
                s_wvalid[k] = 1'b1;
            if (beat_q[k].size() != 0)
                {s_wlast[k], s_wstrb[k*strb_w +: strb_w], s_wdata[k*data_w +: data_w]}
                    = beat_q[k][0];
            s_bready[k] = {$random(seed)} % 4 != 0;
        end
        m_awready = stall_on ? 1'({$random(seed)} % 2) : 1'b1;
        m_wready = w_hold ? 1'b0 : (stall_on ? 1'({$random(seed)} % 2) : 1'b1);
        if (b_taken)
            m_bvalid = 1'b0;
        // Slave answers once both the address and the whole burst are in
        if (!m_bvalid && slv_aw_q.size() != 0 && wlast_done > 0)
        begin
            {m_bid, m_bresp} = slv_aw_q.pop_front();
            m_bvalid = 1'b1;
            wlast_done--;
        end
    endtask

    task automatic sample_outputs();
        int wins, k;
        logic [41:0] aw;
        logic [36:0] beat;
        wins = 0;
        w_taken = '0;
        for (int i = 0; i < master_n; i++)
        begin
            if (s_awvalid[i] && s_awready[i])
            begin
                wins++;
                compare_field("aw winner", rr_winner(s_awvalid, ref_last), i);
                ref_last = i;
                exp_aw_q.push_back({id_w'(i), aw_len_q[i][0], aw_addr_q[i][0]});
                w_ord_q.push_back({id_w'(i), aw_len_q[i][0]});
                exp_b_q[i].push_back(aw_addr_q[i][0][1:0]);
                void'(aw_addr_q[i].pop_front());
                void'(aw_len_q[i].pop_front());
                aw_accepted++;
            end
            if (s_wvalid[i] && s_wready[i])
            begin
                void'(beat_q[i].pop_front());
                w_taken[i] = 1'b1;
            end
        end
        compare_field("aw grants per cycle", wins <= 1, 1);
        compare_field("master w handshakes", $countones(w_taken), m_wvalid && m_wready);
        if (m_awvalid && m_awready)
        begin
            assert (exp_aw_q.size() != 0)
            else
            begin
                $display("Error: test %s slave got an address nobody sent", test_name);
                err_count++;
            end
            if (exp_aw_q.size() != 0)
            begin
                aw = exp_aw_q.pop_front();
                compare_field("awaddr", aw[31:0], m_awaddr);
                compare_field("awlen", aw[39:32], m_awlen);
                compare_field("awid", aw[41:40], m_awid);
            end
            slv_aw_q.push_back({m_awid, m_awaddr[1:0]});
        end
        if (m_wvalid && m_wready)
        begin
            assert (w_ord_q.size() != 0)
            else
            begin
                $display("Error: test %s slave got a data beat with no granted burst",
                         test_name);
                err_count++;
            end
        end
        if (m_wvalid && m_wready && w_ord_q.size() != 0)
        begin
            k = w_ord_q[0][9:8];
            beat = exp_beat_q[k].pop_front();
            compare_field("wdata", beat[31:0], m_wdata);
            compare_field("wstrb", beat[35:32], m_wstrb);
            compare_field("wlast", beat[36], m_wlast);
            beat_cnt++;
            if (m_wlast)
            begin
                compare_field("burst beats", w_ord_q[0][7:0] + 1, beat_cnt);
                beat_cnt = 0;
                void'(w_ord_q.pop_front());
                wlast_done++;
            end
        end
        compare_field("bvalid route", m_bvalid ? (1 << m_bid) : 0, s_bvalid);
        if (m_bvalid)
            compare_field("bready route", s_bready[m_bid], m_bready);
        b_taken = m_bvalid && m_bready;
        if (b_taken)
        begin
            assert (exp_b_q[m_bid].size() != 0)
            else
            begin
                $display("Error: test %s response to master %0d with no write outstanding",
                         test_name, m_bid);
                err_count++;
            end
        end
        if (b_taken && exp_b_q[m_bid].size() != 0)
        begin
            compare_field("bresp", exp_b_q[m_bid].pop_front(),
                          s_bresp[m_bid*resp_w +: resp_w]);
            b_count++;
        end
    endtask

    task automatic wait_all_done();
        while (b_count != tx_count)
            @(negedge clk);
        compare_field("queued addresses left", 0, exp_aw_q.size() + w_ord_q.size());
    endtask

    initial
    begin
        wait (rst_n === 1'b1);
        forever
        begin
            @(negedge clk);
            drive_inputs();
            #1;
            sample_outputs();
        end
    end

    // Watchdog with a budget that grows with every queued write
    initial
    begin
        while (cycles <= budget)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Watchdog timeout in test %s after %0d cycles", test_name, cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        int held;
        rst_n = 1'b0;
        {s_awaddr, s_awlen, s_awvalid, s_wdata, s_wstrb, s_wlast, s_wvalid, s_bready} = '0;
        {m_awready, m_wready, m_bresp, m_bid, m_bvalid, w_taken, b_taken} = '0;
        stall_on = 1'b0;
        w_hold = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "single_write";
        new_write(2, 32'h1000_0042, 3);
        wait_all_done();

        test_name = "round_robin";
        for (int r = 0; r < 4; r++)
            for (int k = 0; k < master_n; k++)
                new_write(k, $random(seed), {$random(seed)} % 4);
        wait_all_done();

        test_name = "random_stall";
        stall_on = 1'b1;
        for (int n = 0; n < 24; n++)
            new_write({$random(seed)} % master_n, $random(seed), {$random(seed)} % 4);
        wait_all_done();

        test_name = "full_queue";
        stall_on = 1'b0;
        w_hold = 1'b1;
        budget += 64;
        held = aw_accepted;
        for (int n = 0; n < 8; n++)
            new_write(n % master_n, $random(seed), 1);
        repeat (30) @(negedge clk);
        held = aw_accepted - held;
        compare_field("accepted with w held", held <= grant_depth + 1 && held > 0, 1);
        held = aw_accepted;
        repeat (10) @(negedge clk);
        compare_field("late acceptance", held, aw_accepted);
        w_hold = 1'b0;
        wait_all_done();

        $display("Checks finished with %0d errors", err_count);
        if (err_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- axi_nm1s_wr_interconnect.f
hdl/axi_ic_pkg.sv
hdl/aw_rr_arbiter.sv
hdl/grant_queue.sv
hdl/wb_router.sv
hdl/axi_nm1s_wr_interconnect.sv
bench/tb_axi_nm1s_wr_interconnect_sva.sv
bench/tb_axi_nm1s_wr_interconnect.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_nm1s_wr_interconnect \
    -f axi_nm1s_wr_interconnect.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
